// ==== verilog/nes_cfg_pkg.sv ====
//////////////////////////////
// nes core configuration
// bridge address map, bus and video widths, and the
// fixed timing constants of the wrapper
//////////////////////////////

package nes_cfg_pkg;

  //////////////////////////////
  // bridge bus
  //////////////////////////////

  localparam int addr_w = 32;
  localparam int data_w = 32;

  // writing here starts the counted external reset
  localparam logic [addr_w-1:0] addr_reset = 32'h0000_0050;

  // video settings
  localparam logic [addr_w-1:0] addr_hide_overscan = 32'h0000_0200;
  localparam logic [addr_w-1:0] addr_mask_edges = 32'h0000_0204;
  localparam logic [addr_w-1:0] addr_extra_sprites = 32'h0000_0208;
  localparam logic [addr_w-1:0] addr_palette = 32'h0000_020C;

  // input settings
  localparam logic [addr_w-1:0] addr_multitap = 32'h0000_0300;
  localparam logic [addr_w-1:0] addr_yb_map = 32'h0000_0310;

  //////////////////////////////
  // timing
  //////////////////////////////

  // external reset length in clk_74a cycles
  localparam int unsigned reset_hold_default = 32'h0010_0000;

  // hsync is pushed out by this many edges so it never lands on vsync
  localparam int hs_delay_cycles = 7;

  //////////////////////////////
  // video and players
  //////////////////////////////

  localparam int rgb_w = 24;
  // slot word carries hide_overscan on this rgb bit
  localparam int slot_hide_bit = 13;

  localparam int num_players = 4;

endpackage

// ==== verilog/nes_io_pkg.sv ====
//////////////////////////////
// nes core io types
// controller bitmap layout, settings word, nes pad
// and the video streams on both sides of the shaper
//////////////////////////////

package nes_io_pkg;

  //////////////////////////////
  // controller
  //////////////////////////////

  // one bit per button as delivered by the host
  typedef logic [15:0] key_t;

  // bit positions inside key_t
  localparam int key_up = 0;
  localparam int key_down = 1;
  localparam int key_left = 2;
  localparam int key_right = 3;
  localparam int key_face_a = 4;
  localparam int key_face_b = 5;
  localparam int key_face_x = 6;
  localparam int key_face_y = 7;
  localparam int key_select = 14;
  localparam int key_start = 15;

  // buttons as the console sees them
  typedef struct packed {
    logic a;
    logic b;
    logic start;
    logic select;
    logic up;
    logic down;
    logic left;
    logic right;
  } pad_t;

  //////////////////////////////
  // settings
  //////////////////////////////

  typedef struct packed {
    logic       hide_overscan;
    logic [1:0] mask_vid_edges;
    logic       allow_extra_sprites;
    logic [2:0] selected_palette;
    logic       multitap_enabled;
    // player one a/b taken from the b/y face buttons
    logic       yb_map;
  } settings_t;

  //////////////////////////////
  // video
  //////////////////////////////

  // raw console output, sync and blanks as levels
  typedef struct packed {
    logic                          h_blank;
    logic                          v_blank;
    logic                          hs;
    logic                          vs;
    logic [nes_cfg_pkg::rgb_w-1:0] rgb;
  } video_in_t;

  // scaler side, syncs are single-cycle pulses
  typedef struct packed {
    logic                          de;
    logic                          hs;
    logic                          vs;
    logic [nes_cfg_pkg::rgb_w-1:0] rgb;
  } video_out_t;

endpackage

// ==== verilog/nes_bridge_regs.sv ====
//////////////////////////////
// bridge settings registers
// decodes host bridge writes into the core settings
// and times the counted external reset
//////////////////////////////

module nes_bridge_regs #(
  parameter int unsigned reset_hold_cycles = nes_cfg_pkg::reset_hold_default
) (
  input  logic                           clk_74a,
  input  logic                           pll_core_locked,
  input  logic [nes_cfg_pkg::addr_w-1:0] bridge_addr,
  input  logic                           bridge_wr,
  input  logic [nes_cfg_pkg::data_w-1:0] bridge_wr_data,
  output nes_io_pkg::settings_t          settings,
  output logic                           external_reset
);

  // wide enough to hold the full reset length
  localparam int hold_w = $clog2(reset_hold_cycles + 1);

  logic [hold_w-1:0] hold_cnt;
  logic              reset_wr;

  assign reset_wr = bridge_wr && (bridge_addr == nes_cfg_pkg::addr_reset);

  //////////////////////////////
  // settings register file
  //////////////////////////////

  // only the low bits of the data word land in each field
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        nes_cfg_pkg::addr_hide_overscan: begin
          settings.hide_overscan <= bridge_wr_data[0];
        end
        nes_cfg_pkg::addr_mask_edges: begin
          settings.mask_vid_edges <= bridge_wr_data[1:0];
        end
        nes_cfg_pkg::addr_extra_sprites: begin
          settings.allow_extra_sprites <= bridge_wr_data[0];
        end
        nes_cfg_pkg::addr_palette: begin
          settings.selected_palette <= bridge_wr_data[2:0];
        end
        nes_cfg_pkg::addr_multitap: begin
          settings.multitap_enabled <= bridge_wr_data[0];
        end
        nes_cfg_pkg::addr_yb_map: begin
          settings.yb_map <= bridge_wr_data[0];
        end
        default: begin
          // unmapped address, nothing to update
        end
      endcase
    end
  end

  //////////////////////////////
  // external reset hold
  //////////////////////////////

  // a fresh reset write reloads the count even mid-hold
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_cnt <= '0;
    end else if (reset_wr) begin
      hold_cnt <= hold_w'(reset_hold_cycles);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // high for exactly reset_hold_cycles cycles after the load
  assign external_reset = (hold_cnt != '0);

endmodule

// ==== verilog/nes_pad_map.sv ====
//////////////////////////////
// controller to nes pad mapper
// picks the console buttons out of each key bitmap,
// with optional y/b remap on player one
//////////////////////////////

module nes_pad_map (
  input  logic             clk_74a,
  input  logic             pll_core_locked,
  input  nes_io_pkg::key_t cont_key [nes_cfg_pkg::num_players],
  input  logic             yb_map,
  output nes_io_pkg::pad_t pads [nes_cfg_pkg::num_players]
);

  nes_io_pkg::pad_t pads_next [nes_cfg_pkg::num_players];

  //////////////////////////////
  // button selection
  //////////////////////////////

  always_comb begin
    for (int p = 0; p < nes_cfg_pkg::num_players; p++) begin
      pads_next[p].up     = cont_key[p][nes_io_pkg::key_up];
      pads_next[p].down   = cont_key[p][nes_io_pkg::key_down];
      pads_next[p].left   = cont_key[p][nes_io_pkg::key_left];
      pads_next[p].right  = cont_key[p][nes_io_pkg::key_right];
      pads_next[p].start  = cont_key[p][nes_io_pkg::key_start];
      pads_next[p].select = cont_key[p][nes_io_pkg::key_select];
      pads_next[p].a      = cont_key[p][nes_io_pkg::key_face_a];
      pads_next[p].b      = cont_key[p][nes_io_pkg::key_face_b];
    end

    // remap applies to player one only
    if (yb_map) begin
      pads_next[0].a = cont_key[0][nes_io_pkg::key_face_b];
      pads_next[0].b = cont_key[0][nes_io_pkg::key_face_y];
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pads <= '{default: '0};
    end else begin
      pads <= pads_next;
    end
  end

endmodule

// ==== verilog/nes_video_shaper.sv ====
//////////////////////////////
// video shaper
// turns console blanks and sync levels into scaler
// data enable, sync pulses and the slot word
//////////////////////////////

module nes_video_shaper (
  input  logic                   clk_74a,
  input  logic                   pll_core_locked,
  input  nes_io_pkg::video_in_t  video_in,
  input  logic                   hide_overscan,
  output nes_io_pkg::video_out_t video_out
);

  localparam int hs_delay_w = $clog2(nes_cfg_pkg::hs_delay_cycles + 1);

  logic                          de;
  logic                          de_fall;
  logic                          hs_rise;
  logic                          hs_prev;
  logic                          vs_prev;
  logic                          de_prev;
  logic [hs_delay_w-1:0]         hs_delay;
  logic [nes_cfg_pkg::rgb_w-1:0] slot_rgb;

  // visible pixel whenever neither blank is active
  assign de      = !(video_in.h_blank || video_in.v_blank);
  assign de_fall = de_prev && !de;
  assign hs_rise = !hs_prev && video_in.hs;

  // slot word, everything zero except the overscan flag
  assign slot_rgb = {{(nes_cfg_pkg::rgb_w - 1){1'b0}}, hide_overscan}
                    << nes_cfg_pkg::slot_hide_bit;

  //////////////////////////////
  // previous samples
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_prev <= 1'b0;
      vs_prev <= 1'b0;
      de_prev <= 1'b0;
    end else begin
      hs_prev <= video_in.hs;
      vs_prev <= video_in.vs;
      de_prev <= de;
    end
  end

  //////////////////////////////
  // hsync delay
  //////////////////////////////

  // a new rise restarts the count from the top
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_delay <= '0;
    end else if (hs_rise) begin
      hs_delay <= hs_delay_w'(nes_cfg_pkg::hs_delay_cycles);
    end else if (hs_delay != '0) begin
      hs_delay <= hs_delay - 1'b1;
    end
  end

  //////////////////////////////
  // output stage
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_out <= '0;
    end else begin
      video_out.de <= de;
      // pulse on the last step of the delay count
      video_out.hs <= (hs_delay == hs_delay_w'(1));
      // vsync rise becomes a single-cycle pulse
      video_out.vs <= !vs_prev && video_in.vs;

      if (de) begin
        video_out.rgb <= video_in.rgb;
      end else if (de_fall) begin
        video_out.rgb <= slot_rgb;
      end else begin
        video_out.rgb <= '0;
      end
    end
  end

endmodule

// ==== verilog/nes_core_top.sv ====
//////////////////////////////
// nes core wrapper top
// settings registers, pad mapper and video shaper
// between the host bridge and the console
//////////////////////////////

module nes_core_top #(
  parameter int unsigned reset_hold_cycles = nes_cfg_pkg::reset_hold_default
) (
  input  logic                           clk_74a,
  input  logic                           pll_core_locked,

  // host bridge, writes only
  input  logic [nes_cfg_pkg::addr_w-1:0] bridge_addr,
  input  logic                           bridge_wr,
  input  logic [nes_cfg_pkg::data_w-1:0] bridge_wr_data,

  // controllers, player one first
  input  nes_io_pkg::key_t               cont_key [nes_cfg_pkg::num_players],

  // console video
  input  nes_io_pkg::video_in_t          video_in,

  output nes_io_pkg::settings_t          settings,
  output logic                           external_reset,
  output nes_io_pkg::pad_t               pads [nes_cfg_pkg::num_players],
  output nes_io_pkg::video_out_t         video_out
);

  nes_bridge_regs #(
    .reset_hold_cycles(reset_hold_cycles)
  ) u_bridge_regs (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .settings       (settings),
    .external_reset (external_reset)
  );

  nes_pad_map u_pad_map (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .cont_key       (cont_key),
    .yb_map         (settings.yb_map),
    .pads           (pads)
  );

  nes_video_shaper u_video_shaper (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .video_in       (video_in),
    .hide_overscan  (settings.hide_overscan),
    .video_out      (video_out)
  );

endmodule

// ==== sim/nes_core_checker.sv ====
//////////////////////////////
// nes core checker
// sync pulse width and reset quiet assertions
//////////////////////////////

module nes_core_checker #(
  parameter bit sync_checks  = 1'b1,
  parameter bit reset_checks = 1'b1
) (
  input logic clk_74a,
  input logic pll_core_locked,
  input logic vs,
  input logic hs,
  input logic external_reset
);

  // failures so far, summed into the verdict
  int unsigned assert_errors = 0;

  // scaler expects single-cycle syncs
  if (sync_checks) begin : g_sync
    a_vs_single: assert property (
      @(posedge clk_74a) disable iff (!pll_core_locked) vs |=> !vs
    ) else begin
      assert_errors++;
      $error("vs pulse lasted more than one cycle");
    end

    a_hs_single: assert property (
      @(posedge clk_74a) disable iff (!pll_core_locked) hs |=> !hs
    ) else begin
      assert_errors++;
      $error("hs pulse lasted more than one cycle");
    end
  end

  // no external reset while the core clock is unlocked
  if (reset_checks) begin : g_reset
    a_reset_quiet: assert property (
      @(posedge clk_74a) !pll_core_locked |-> !external_reset
    ) else begin
      assert_errors++;
      $error("external_reset high while pll_core_locked is low");
    end
  end

endmodule

bind nes_video_shaper nes_core_checker #(
  .reset_checks(1'b0)
) u_shaper_checker (
  .clk_74a        (clk_74a),
  .pll_core_locked(pll_core_locked),
  .vs             (video_out.vs),
  .hs             (video_out.hs),
  .external_reset (1'b0)
);

bind nes_bridge_regs nes_core_checker #(
  .sync_checks(1'b0)
) u_regs_checker (
  .clk_74a        (clk_74a),
  .pll_core_locked(pll_core_locked),
  .vs             (1'b0),
  .hs             (1'b0),
  .external_reset (external_reset)
);

// ==== sim/nes_core_tb.sv ====
//////////////////////////////
// nes core wrapper testbench
// table-driven bridge, controller and video stimulus
// checked against the wrapper rules
//////////////////////////////

module nes_core_tb;

  localparam int unsigned hold_cycles = 16;
  localparam int np = nes_cfg_pkg::num_players;

  typedef enum logic [1:0] {row_idle, row_write, row_keys, row_video} row_kind_t;

  // one clock step of stimulus and the response expected one cycle later
  typedef struct packed {
    row_kind_t                      kind;
    logic                           wr;
    logic [nes_cfg_pkg::addr_w-1:0] addr;
    logic [nes_cfg_pkg::data_w-1:0] data;
    nes_io_pkg::key_t [np-1:0]      keys;
    nes_io_pkg::video_in_t          vin;
    nes_io_pkg::settings_t          exp_set;
    logic                           exp_rst;
    nes_io_pkg::pad_t [np-1:0]      exp_pads;
    nes_io_pkg::video_out_t         exp_vid;
  } row_t;

  logic                           clk_74a;
  logic                           pll_core_locked;
  logic [nes_cfg_pkg::addr_w-1:0] bridge_addr;
  logic                           bridge_wr;
  logic [nes_cfg_pkg::data_w-1:0] bridge_wr_data;
  nes_io_pkg::key_t               cont_key [np];
  nes_io_pkg::video_in_t          video_in;
  nes_io_pkg::settings_t          settings;
  logic                           external_reset;
  nes_io_pkg::pad_t               pads [np];
  nes_io_pkg::video_out_t         video_out;

  row_t        rows[$];
  int unsigned errors;
  int unsigned assert_total;
  integer      seed;

  // reference state while the table is built
  nes_io_pkg::key_t [np-1:0] cur_keys;
  nes_io_pkg::video_in_t     cur_vin;
  nes_io_pkg::settings_t     m_set;
  int                        m_rst_left;
  int                        m_hs_pulse;
  logic                      m_prev_hs;
  logic                      m_prev_vs;
  logic                      m_prev_de;

  nes_core_top #(
    .reset_hold_cycles(hold_cycles)
  ) u_nes_core_top (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .cont_key       (cont_key),
    .video_in       (video_in),
    .settings       (settings),
    .external_reset (external_reset),
    .pads           (pads),
    .video_out      (video_out)
  );

  initial begin
    clk_74a = 1'b0;
    forever #5 clk_74a = ~clk_74a;
  end

  //////////////////////////////
  // expected value rules
  //////////////////////////////

  function automatic nes_io_pkg::pad_t expect_pad(input nes_io_pkg::key_t k, input logic remap);
    nes_io_pkg::pad_t p;
    p.up     = k[nes_io_pkg::key_up];
    p.down   = k[nes_io_pkg::key_down];
    p.left   = k[nes_io_pkg::key_left];
    p.right  = k[nes_io_pkg::key_right];
    p.start  = k[nes_io_pkg::key_start];
    p.select = k[nes_io_pkg::key_select];
    p.a      = remap ? k[nes_io_pkg::key_face_b] : k[nes_io_pkg::key_face_a];
    p.b      = remap ? k[nes_io_pkg::key_face_y] : k[nes_io_pkg::key_face_b];
    return p;
  endfunction

  function automatic logic [nes_cfg_pkg::rgb_w-1:0] slot_word(input logic hide);
    logic [nes_cfg_pkg::rgb_w-1:0] w;
    w = '0;
    w[nes_cfg_pkg::slot_hide_bit] = hide;
    return w;
  endfunction

  // pads and video see the settings from before this row's write
  task automatic push_row(input row_kind_t kind, input logic wr,
                          input logic [31:0] addr, input logic [31:0] data);
    row_t r;
    logic de_now;
    r = '0;
    r.kind = kind;
    r.wr = wr;
    r.addr = addr;
    r.data = data;
    r.keys = cur_keys;
    r.vin = cur_vin;
    for (int p = 0; p < np; p++) begin
      r.exp_pads[p] = expect_pad(cur_keys[p], (p == 0) && m_set.yb_map);
    end
    de_now = !(cur_vin.h_blank || cur_vin.v_blank);
    if (cur_vin.hs && !m_prev_hs) begin
      m_hs_pulse = rows.size() + nes_cfg_pkg::hs_delay_cycles;
    end
    r.exp_vid.de = de_now;
    r.exp_vid.vs = cur_vin.vs && !m_prev_vs;
    r.exp_vid.hs = (rows.size() == m_hs_pulse);
    r.exp_vid.rgb = de_now ? cur_vin.rgb : (m_prev_de ? slot_word(m_set.hide_overscan) : '0);
    m_prev_hs = cur_vin.hs;
    m_prev_vs = cur_vin.vs;
    m_prev_de = de_now;
    if (wr) begin
      case (addr)
        nes_cfg_pkg::addr_hide_overscan: m_set.hide_overscan = data[0];
        nes_cfg_pkg::addr_mask_edges: m_set.mask_vid_edges = data[1:0];
        nes_cfg_pkg::addr_extra_sprites: m_set.allow_extra_sprites = data[0];
        nes_cfg_pkg::addr_palette: m_set.selected_palette = data[2:0];
        nes_cfg_pkg::addr_multitap: m_set.multitap_enabled = data[0];
        nes_cfg_pkg::addr_yb_map: m_set.yb_map = data[0];
        nes_cfg_pkg::addr_reset: m_rst_left = hold_cycles;
        default: ;
      endcase
    end
    r.exp_set = m_set;
    r.exp_rst = (m_rst_left != 0);
    if (m_rst_left != 0) begin
      m_rst_left--;
    end
    rows.push_back(r);
  endtask

  task automatic add_write(input logic [31:0] addr, input logic [31:0] data);
    push_row(row_write, 1'b1, addr, data);
  endtask

  task automatic add_idle(input int n);
    repeat (n) push_row(row_idle, 1'b0, '0, '0);
  endtask

  task automatic add_keys();
    int rnd;
    for (int p = 0; p < np; p++) begin
      rnd = $random(seed);
      cur_keys[p] = rnd[15:0];
    end
    push_row(row_keys, 1'b0, '0, '0);
  endtask

  // rgb stays random in blanking too, it must not leak out
  task automatic add_video(input logic hb, input logic vb, input logic hs, input logic vs);
    int rnd;
    rnd = $random(seed);
    cur_vin.h_blank = hb;
    cur_vin.v_blank = vb;
    cur_vin.hs = hs;
    cur_vin.vs = vs;
    cur_vin.rgb = rnd[23:0];
    push_row(row_video, 1'b0, '0, '0);
  endtask

  task automatic build_rows();
    add_idle(2);
    // settings, high data bits ignored
    add_write(nes_cfg_pkg::addr_hide_overscan, 32'hffff_fff1);
    add_write(nes_cfg_pkg::addr_mask_edges, 32'h0000_0006);
    add_write(nes_cfg_pkg::addr_extra_sprites, 32'h0000_0003);
    add_write(nes_cfg_pkg::addr_palette, 32'hffff_fffd);
    add_write(nes_cfg_pkg::addr_multitap, 32'h0000_0001);
    add_write(32'h0000_0214, 32'hffff_ffff);
    add_write(32'h0000_0051, 32'hffff_ffff);
    // address without write strobe
    push_row(row_idle, 1'b0, nes_cfg_pkg::addr_palette, 32'h0000_0002);
    add_write(nes_cfg_pkg::addr_yb_map, 32'h0000_0001);
    // external reset, restarted midway
    add_write(nes_cfg_pkg::addr_reset, 32'h0);
    add_idle(8);
    add_write(nes_cfg_pkg::addr_reset, 32'h0);
    add_idle(hold_cycles + 3);
    // pads with remap on, then off
    repeat (6) add_keys();
    add_write(nes_cfg_pkg::addr_yb_map, 32'hffff_fffe);
    repeat (6) add_keys();
    // visible, blank with slot word, then again with hide_overscan clear
    repeat (3) add_video(1'b0, 1'b0, 1'b0, 1'b0);
    repeat (3) add_video(1'b1, 1'b0, 1'b0, 1'b0);
    add_video(1'b0, 1'b0, 1'b0, 1'b0);
    add_write(nes_cfg_pkg::addr_hide_overscan, 32'h0);
    repeat (2) add_video(1'b0, 1'b1, 1'b0, 1'b0);
    // vsync level held high
    repeat (3) add_video(1'b1, 1'b1, 1'b0, 1'b1);
    add_video(1'b1, 1'b1, 1'b0, 1'b0);
    // hsync rise, then a second rise that restarts the delay
    repeat (2) add_video(1'b1, 1'b0, 1'b1, 1'b0);
    repeat (9) add_video(1'b1, 1'b0, 1'b0, 1'b0);
    repeat (2) add_video(1'b1, 1'b0, 1'b1, 1'b0);
    repeat (2) add_video(1'b1, 1'b0, 1'b0, 1'b0);
    add_video(1'b1, 1'b0, 1'b1, 1'b0);
    repeat (10) add_video(1'b1, 1'b0, 1'b0, 1'b0);
  endtask

  //////////////////////////////
  // drive and compare
  //////////////////////////////

  task automatic drive_row(input row_t r);
    bridge_addr <= r.addr;
    bridge_wr <= r.wr;
    bridge_wr_data <= r.data;
    for (int p = 0; p < np; p++) begin
      cont_key[p] <= r.keys[p];
    end
    video_in <= r.vin;
  endtask

  task automatic check_settings(input string tag, input nes_io_pkg::settings_t got,
                                input nes_io_pkg::settings_t exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s settings: got %h expected %h", tag, got, exp);
    end
  endtask

  task automatic check_reset(input string tag, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s external_reset: got %h expected %h", tag, got, exp);
    end
  endtask

  task automatic check_pad(input string tag, input int p, input nes_io_pkg::pad_t got,
                           input nes_io_pkg::pad_t exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s pads[%0d]: got %h expected %h", tag, p, got, exp);
    end
  endtask

  task automatic check_video(input string tag, input nes_io_pkg::video_out_t got,
                             input nes_io_pkg::video_out_t exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s video_out: got %h expected %h", tag, got, exp);
    end
  endtask

  task automatic check_row(input string tag, input row_t r);
    check_settings(tag, settings, r.exp_set);
    check_reset(tag, external_reset, r.exp_rst);
    for (int p = 0; p < np; p++) begin
      check_pad(tag, p, pads[p], r.exp_pads[p]);
    end
    check_video(tag, video_out, r.exp_vid);
  endtask

  task automatic watchdog(input int unsigned cycles);
    repeat (cycles) @(posedge clk_74a);
    $display("timeout: run did not finish within %0d cycles", cycles);
    $display(">>> FAIL");
    $finish;
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    errors = 0;
    seed = 32'hb944_2516;
    pll_core_locked = 1'b0;
    bridge_addr = '0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    cur_keys = '0;
    cur_vin = '0;
    // start fully blanked so de stays low after release
    cur_vin.h_blank = 1'b1;
    cur_vin.v_blank = 1'b1;
    for (int p = 0; p < np; p++) begin
      cont_key[p] = '0;
    end
    video_in = cur_vin;
    m_set = '0;
    m_rst_left = 0;
    m_hs_pulse = -1;
    m_prev_hs = 1'b0;
    m_prev_vs = 1'b0;
    m_prev_de = 1'b0;
    build_rows();
    fork
      watchdog(rows.size() * 20 + hold_cycles * 4);
    join_none

    repeat (2) @(posedge clk_74a);
    @(negedge clk_74a);
    check_row("reset", row_t'('0));
    @(posedge clk_74a);
    pll_core_locked <= 1'b1;

    // outputs at each negedge answer the row driven one edge earlier
    for (int i = 0; i <= rows.size(); i++) begin
      @(posedge clk_74a);
      if (i < rows.size()) begin
        drive_row(rows[i]);
      end
      @(negedge clk_74a);
      if (i > 0) begin
        check_row($sformatf("row %0d %s", i - 1, rows[i - 1].kind.name()), rows[i - 1]);
      end
    end

    assert_total = u_nes_core_top.u_video_shaper.u_shaper_checker.assert_errors
                 + u_nes_core_top.u_bridge_regs.u_regs_checker.assert_errors;
    $display("%0d rows, %0d value errors, %0d assertion errors",
             rows.size(), errors, assert_total);
    if (errors == 0 && assert_total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/nes_cfg_pkg.sv
verilog/nes_io_pkg.sv
verilog/nes_bridge_regs.sv
verilog/nes_pad_map.sv
verilog/nes_video_shaper.sv
verilog/nes_core_top.sv
sim/nes_core_checker.sv
sim/nes_core_tb.sv
